/* all.f */
rtl/gpuMemPkg.sv
rtl/burstReqIf.sv
rtl/beatIf.sv
rtl/requestArbiter.sv
rtl/burstSequencer.sv
rtl/cacheFeed.sv
rtl/memArbiter.sv
tests/ddrModel.sv
tests/memArbiterTb.sv

/* rtl/beatIf.sv */
`timescale 1ns/1ps

// Read beats from the sequencer toward the caches
interface beatIf import gpuMemPkg::*; ();

	logic                beat;		// One per acked read word
	logic [6:0]          beatIdx;
	logic [busDataW-1:0] data;
	burstKindE           kind;
	logic                texRight;
	logic [vramAdrW-1:0] baseAdr;	// Start of the running burst
	logic                last;		// First cycle after the final beat

	modport src (output beat, beatIdx, data, kind, texRight, baseAdr, last);
	modport dst (input beat, beatIdx, data, kind, texRight, baseAdr, last);

endinterface

/* rtl/burstReqIf.sv */
`timescale 1ns/1ps

// One selected burst, arbiter to sequencer
interface burstReqIf import gpuMemPkg::*; ();

	logic                start;		// Single cycle, only while idle
	burstKindE           kind;
	logic [vramAdrW-1:0] baseAdr;	// Byte address of beat 0
	logic [6:0]          beatCount;	// Beats minus one
	logic [busDataW-1:0] fillWord;
	logic [1:0]          fillMask;	// One bit per 16 bit pixel
	logic [2:0]          pairId;	// Word slot inside the block for pair writes
	logic                texRight;
	logic                idle;		// Sequencer free

	modport arb (output start, kind, baseAdr, beatCount, fillWord, fillMask, pairId,
		texRight, input idle);
	modport seq (input start, kind, baseAdr, beatCount, fillWord, fillMask, pairId,
		texRight, output idle);

endinterface

/* rtl/burstSequencer.sv */
`timescale 1ns/1ps

module burstSequencer import gpuMemPkg::*; (
	input  logic                gpuClk,
	input  logic                resetX,
	burstReqIf.seq              bus,
	beatIf.src                  beats,
	// DDR burst bus
	output logic [vramAdrW-1:0] adr_o,
	input  logic [busDataW-1:0] dat_i,
	output logic [busDataW-1:0] dat_o,
	output logic [6:0]          cnt_o,
	output logic [3:0]          sel_o,
	output logic                wrt_o,
	output logic                req_o,
	input  logic                ack_i
);

	logic [1:0]          state;
	logic [6:0]          beatCnt;
	// Burst parameters, held for the whole burst
	burstKindE           kindR;
	logic [vramAdrW-1:0] baseR;
	logic [6:0]          cntR;
	logic [busDataW-1:0] wordR;
	logic [1:0]          maskR;
	logic [2:0]          pairIdR;
	logic                rightR;

	logic                isWrite;
	logic                active;
	logic                inBurst;
	logic [8:0]          stepAdr;	// Byte offset from the base

	assign isWrite = (kindR == kindFill) | (kindR == kindPair);
	assign active  = (state != seqIdle);
	assign inBurst = (state == seqBurst);

	// ----------------------------------------------------------------------
	// Bus FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			state   <= seqIdle;
			beatCnt <= 7'd0;
		end else begin
			case (state)
				seqIdle: begin
					if (bus.start) begin
						state   <= seqWait;
						beatCnt <= 7'd0;
					end
				end
				seqWait: begin
					// Slave may stall here as long as it likes
					if (ack_i) begin
						state   <= seqBurst;
						beatCnt <= beatCnt + 7'd1;
					end
				end
				seqBurst: begin
					if (ack_i)
						beatCnt <= beatCnt + 7'd1;
					else
						state <= seqIdle;	// Ack run over
				end
				default: state <= seqIdle;
			endcase
		end
	end

	// Take the burst from the arbiter
	always_ff @(posedge gpuClk) begin
		if (bus.start & ~active) begin
			kindR   <= bus.kind;
			baseR   <= bus.baseAdr;
			cntR    <= bus.beatCount;
			wordR   <= bus.fillWord;
			maskR   <= bus.fillMask;
			pairIdR <= bus.pairId;
			rightR  <= bus.texRight;
		end
	end

	// Pair write targets one word slot; all other bursts walk the words
	assign stepAdr = (kindR == kindPair) ? {4'd0, pairIdR, 2'b00} : {beatCnt, 2'b00};

	assign adr_o = baseR + {11'd0, stepAdr};
	assign cnt_o = cntR;
	assign dat_o = wordR;
	assign sel_o = isWrite ? {maskR[1], maskR[1], maskR[0], maskR[0]} : 4'hF;
	assign wrt_o = isWrite & active;
	// Drops in the very cycle the ack run ends
	assign req_o = (state == seqWait) | (inBurst & ack_i);

	assign bus.idle = ~active;

	// Read beats toward the caches
	assign beats.beat     = ack_i & active & ~isWrite;
	assign beats.beatIdx  = beatCnt;
	assign beats.data     = dat_i;
	assign beats.kind     = kindR;
	assign beats.texRight = rightR;
	assign beats.baseAdr  = baseR;
	assign beats.last     = inBurst & ~ack_i;

endmodule

/* rtl/cacheFeed.sv */
`timescale 1ns/1ps

module cacheFeed import gpuMemPkg::*; (
	input  logic                gpuClk,
	input  logic                resetX,
	beatIf.dst                  beats,
	// Texture cache fill
	output logic                texWrite_o,
	output logic [texAdrW-1:0]  texWriteAdr_o,
	output logic [63:0]         texData_o,
	output logic                texDoneL_o,
	output logic                texDoneR_o,
	// Palette cache fill
	output logic                clutWrite_o,
	output logic [6:0]          clutIndex_o,
	output logic [busDataW-1:0] clutData_o,
	output logic                clutDone_o
);

	logic                texBeat;
	logic                clutBeat;
	logic                texEnd;
	logic [busDataW-1:0] texLoR;	// Word 0 of the line
	logic [busDataW-1:0] texHiR;
	logic [texAdrW-1:0]  lineAdrR;
	logic                clutWriteR;
	logic [6:0]          clutIdxR;
	logic [busDataW-1:0] clutDataR;

	assign texBeat  = beats.beat & (beats.kind == kindTex);
	assign clutBeat = beats.beat & (beats.kind == kindClut);
	assign texEnd   = beats.last & (beats.kind == kindTex);

	always_ff @(posedge gpuClk) begin
		if (resetX)
			clutWriteR <= 1'b0;
		else
			clutWriteR <= clutBeat;	// One palette write per beat
	end

	always_ff @(posedge gpuClk) begin
		if (texBeat) begin
			if (beats.beatIdx[0]) begin
				texHiR <= beats.data;
			end else begin
				texLoR   <= beats.data;
				lineAdrR <= beats.baseAdr[vramAdrW-1:3];	// Back to 8 byte units
			end
		end
		if (clutBeat) begin
			clutIdxR  <= beats.beatIdx;
			clutDataR <= beats.data;
		end
	end

	// Line is complete once the burst has ended
	assign texWrite_o    = texEnd;
	assign texWriteAdr_o = lineAdrR;
	assign texData_o     = {texHiR, texLoR};
	assign texDoneL_o    = texEnd & ~beats.texRight;
	assign texDoneR_o    = texEnd & beats.texRight;

	assign clutWrite_o = clutWriteR;
	assign clutIndex_o = clutIdxR;
	assign clutData_o  = clutDataR;
	assign clutDone_o  = beats.last & (beats.kind == kindClut);	// Lines up with final write

endmodule

/* rtl/gpuMemPkg.sv */
package gpuMemPkg;

	// ----------------------------------------------------------------------
	// Widths
	// ----------------------------------------------------------------------
	localparam int vramAdrW = 20;	// Byte address over 1 MB of VRAM
	localparam int busDataW = 32;	// DDR word
	localparam int texAdrW  = 17;	// Texture line in 8 byte units
	localparam int blkAdrW  = 15;	// Block in 32 byte units
	localparam int cmdW     = 56;

	// Command opcodes in bits [2:0]
	localparam logic [2:0] cmdNone    = 3'd0;
	localparam logic [2:0] cmdPixPair = 3'd1;
	localparam logic [2:0] cmdFill    = 3'd2;

	// Burst lengths in words
	localparam int clutBeats4 = 8;		// 4bpp palette
	localparam int clutBeats8 = 128;	// 8bpp palette
	localparam int texBeats   = 2;
	localparam int fillBeats  = 8;

	// Bus sequencer states
	localparam logic [1:0] seqIdle  = 2'd0;
	localparam logic [1:0] seqWait  = 2'd1;	// Request up, no ack yet
	localparam logic [1:0] seqBurst = 2'd2;

	typedef enum logic [1:0] {kindFill, kindPair, kindClut, kindTex} burstKindE;

	// Pixel pair view of the command word
	typedef struct packed {
		logic [15:0]        colorL;		// [55:40]
		logic [15:0]        colorR;		// [39:24]
		logic [1:0]         validPair;	// [23:22]
		logic [blkAdrW-1:0] blkAdr;		// [21:7]
		logic [2:0]         pairId;		// [6:4]
		logic               rsv;
		logic [2:0]         op;
	} pairCmdS;

	// Fill view, one colour for the whole block
	typedef struct packed {
		logic [15:0]        color;		// [55:40]
		logic [17:0]        unused;
		logic [blkAdrW-1:0] blkAdr;
		logic [2:0]         pairId;
		logic               rsv;
		logic [2:0]         op;
	} fillCmdS;

	typedef union packed {
		pairCmdS pair;
		fillCmdS fill;
	} memCmdU;

endpackage

/* rtl/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter import gpuMemPkg::*; (
	input  logic                gpuClk,
	input  logic                resetX,
	// ----------------------------------------------------------------------
	// GPU side
	// ----------------------------------------------------------------------
	input  logic [cmdW-1:0]     cmdWord_i,	// Non zero op takes a command
	output logic                cmdReady_o,
	output logic                busy_o,
	input  logic                clutReq_i,
	input  logic                clut8Bpp_i,
	input  logic [blkAdrW-1:0]  clutAdr_i,
	input  logic                texReqL_i,
	input  logic [texAdrW-1:0]  texAdrL_i,
	input  logic                texReqR_i,
	input  logic [texAdrW-1:0]  texAdrR_i,
	output logic                texWrite_o,
	output logic [texAdrW-1:0]  texWriteAdr_o,
	output logic [63:0]         texData_o,
	output logic                texDoneL_o,
	output logic                texDoneR_o,
	output logic                clutWrite_o,
	output logic [6:0]          clutIndex_o,
	output logic [busDataW-1:0] clutData_o,
	output logic                clutDone_o,
	// ----------------------------------------------------------------------
	// DDR side
	// ----------------------------------------------------------------------
	output logic [vramAdrW-1:0] adr_o,
	input  logic [busDataW-1:0] dat_i,
	output logic [busDataW-1:0] dat_o,
	output logic [6:0]          cnt_o,
	output logic [3:0]          sel_o,
	output logic                wrt_o,
	output logic                req_o,
	input  logic                ack_i
);

	burstReqIf burstBus ();
	beatIf     beatBus ();

	requestArbiter uArb (
		.gpuClk     (gpuClk),
		.resetX     (resetX),
		.cmdWord_i  (cmdWord_i),
		.cmdReady_o (cmdReady_o),
		.clutReq_i  (clutReq_i),
		.clut8Bpp_i (clut8Bpp_i),
		.clutAdr_i  (clutAdr_i),
		.texReqL_i  (texReqL_i),
		.texAdrL_i  (texAdrL_i),
		.texReqR_i  (texReqR_i),
		.texAdrR_i  (texAdrR_i),
		.busy_o     (busy_o),
		.bus        (burstBus.arb)
	);

	burstSequencer uSeq (
		.gpuClk (gpuClk),
		.resetX (resetX),
		.bus    (burstBus.seq),
		.beats  (beatBus.src),
		.adr_o  (adr_o),
		.dat_i  (dat_i),
		.dat_o  (dat_o),
		.cnt_o  (cnt_o),
		.sel_o  (sel_o),
		.wrt_o  (wrt_o),
		.req_o  (req_o),
		.ack_i  (ack_i)
	);

	cacheFeed uFeed (
		.gpuClk        (gpuClk),
		.resetX        (resetX),
		.beats         (beatBus.dst),
		.texWrite_o    (texWrite_o),
		.texWriteAdr_o (texWriteAdr_o),
		.texData_o     (texData_o),
		.texDoneL_o    (texDoneL_o),
		.texDoneR_o    (texDoneR_o),
		.clutWrite_o   (clutWrite_o),
		.clutIndex_o   (clutIndex_o),
		.clutData_o    (clutData_o),
		.clutDone_o    (clutDone_o)
	);

endmodule

/* rtl/requestArbiter.sv */
`timescale 1ns/1ps

module requestArbiter import gpuMemPkg::*; (
	input  logic               gpuClk,
	input  logic               resetX,
	// Command side
	input  memCmdU             cmdWord_i,
	output logic               cmdReady_o,
	// CLUT cache miss
	input  logic               clutReq_i,
	input  logic               clut8Bpp_i,
	input  logic [blkAdrW-1:0] clutAdr_i,
	// Texture cache misses
	input  logic               texReqL_i,
	input  logic [texAdrW-1:0] texAdrL_i,
	input  logic               texReqR_i,
	input  logic [texAdrW-1:0] texAdrR_i,
	output logic               busy_o,
	burstReqIf.arb             bus
);

	logic                busyR;
	logic                startR;
	logic                canPick;
	logic                cmdTake;
	logic                anyTake;
	// Next burst, picked combinationally
	burstKindE           kindSel;
	logic [vramAdrW-1:0] adrSel;
	logic [6:0]          cntSel;
	logic [busDataW-1:0] wordSel;
	logic [1:0]          maskSel;
	logic                rightSel;
	// Latched burst
	burstKindE           kindR;
	logic [vramAdrW-1:0] adrR;
	logic [6:0]          cntR;
	logic [busDataW-1:0] wordR;
	logic [1:0]          maskR;
	logic [2:0]          pairIdR;
	logic                rightR;

	assign canPick    = bus.idle & ~busyR;
	assign cmdReady_o = canPick;
	assign cmdTake    = canPick & (cmdWord_i.pair.op != cmdNone);
	assign anyTake    = cmdTake | (canPick & (clutReq_i | texReqL_i | texReqR_i));

	// ----------------------------------------------------------------------
	// Fixed priority: command > CLUT > texture L > texture R
	// ----------------------------------------------------------------------
	always_comb begin
		kindSel  = kindTex;
		adrSel   = {texAdrR_i, 3'b000};	// 8 byte line
		cntSel   = 7'(texBeats - 1);
		wordSel  = {cmdWord_i.pair.colorR, cmdWord_i.pair.colorL};
		maskSel  = cmdWord_i.pair.validPair;
		rightSel = 1'b1;
		if (cmdTake) begin
			adrSel   = {cmdWord_i.pair.blkAdr, 5'b00000};	// 32 byte block
			kindSel  = kindPair;	// Unknown opcodes fall here too
			cntSel   = 7'd0;
			rightSel = 1'b0;
			case (cmdWord_i.pair.op)
				cmdFill: begin
					kindSel = kindFill;
					cntSel  = 7'(fillBeats - 1);
					wordSel = {cmdWord_i.fill.color, cmdWord_i.fill.color};
					maskSel = 2'b11;
				end
				cmdPixPair: maskSel = cmdWord_i.pair.validPair;
				default:    maskSel = 2'b00;	// Harmless write, no byte lanes
			endcase
		end else if (clutReq_i) begin
			kindSel  = kindClut;
			adrSel   = {clutAdr_i, 5'b00000};
			cntSel   = clut8Bpp_i ? 7'(clutBeats8 - 1) : 7'(clutBeats4 - 1);
			rightSel = 1'b0;
		end else if (texReqL_i) begin
			adrSel   = {texAdrL_i, 3'b000};
			rightSel = 1'b0;
		end
	end

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			busyR  <= 1'b0;
			startR <= 1'b0;
		end else begin
			startR <= anyTake;
			if (anyTake)
				busyR <= 1'b1;
			else if (bus.idle & ~startR)	// Sequencer back to idle
				busyR <= 1'b0;
		end
	end

	always_ff @(posedge gpuClk) begin
		if (anyTake) begin
			kindR   <= kindSel;
			adrR    <= adrSel;
			cntR    <= cntSel;
			wordR   <= wordSel;
			maskR   <= maskSel;
			pairIdR <= cmdWord_i.pair.pairId;
			rightR  <= rightSel;
		end
	end

	assign busy_o        = busyR;
	assign bus.start     = startR;
	assign bus.kind      = kindR;
	assign bus.baseAdr   = adrR;
	assign bus.beatCount = cntR;
	assign bus.fillWord  = wordR;
	assign bus.fillMask  = maskR;
	assign bus.pairId    = pairIdR;
	assign bus.texRight  = rightR;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the memArbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module memArbiterTb -f all.f -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

/* tests/ddrModel.sv */
`timescale 1ns/1ps

// Burst slave for the DDR side of the arbiter
module ddrModel import gpuMemPkg::*; (
	input  logic                gpuClk,
	input  logic                req_i,
	input  logic                wrt_i,
	input  logic [6:0]          cnt_i,		// Beats minus one
	input  logic [vramAdrW-1:0] adr_i,
	input  logic [busDataW-1:0] dat_i,		// Write data from the DUT
	input  logic [3:0]          sel_i,
	output logic                ack_o,
	output logic [busDataW-1:0] dat_o		// Read data toward the DUT
);

	logic [55:0] wrLog[$];	// {adr, data, byte enables} per write beat

	// Read word is the word address times 0x00010001
	assign dat_o = {14'd0, adr_i[vramAdrW-1:2]} * 32'h00010001;

	always @(negedge gpuClk) begin
		if (ack_o && wrt_i)
			wrLog.push_back({adr_i, dat_i, sel_i});
	end

	// ----------------------------------------------------------------------
	// Ack sequencing, random stall of 0 to 5 cycles
	// ----------------------------------------------------------------------
	initial begin
		int nBeats;
		int waitCyc;
		ack_o = 1'b0;
		void'($urandom(32));	// Fixed seed
		forever begin
			@(negedge gpuClk);
			if (req_i && !ack_o) begin
				nBeats  = int'(cnt_i) + 1;
				waitCyc = $urandom_range(5, 0);
				repeat (waitCyc) @(posedge gpuClk);
				@(posedge gpuClk);
				#1 ack_o = 1'b1;	// One beat per cycle from here
				repeat (nBeats) @(posedge gpuClk);
				#1 ack_o = 1'b0;
			end
		end
	end

endmodule

/* tests/memArbiterTb.sv */
`timescale 1ns/1ps

module memArbiterTb import gpuMemPkg::*; ();

	localparam int numTests = 7;

	// One row of the stimulus table
	typedef struct packed {
		logic [3:0]          reqMask;	// Bit 0 cmd, 1 CLUT, 2 tex L, 3 tex R
		logic [cmdW-1:0]     cmd;
		logic [blkAdrW-1:0]  clutAdr;
		logic                clut8;
		logic [texAdrW-1:0]  texAdrL;
		logic [texAdrW-1:0]  texAdrR;
		logic [vramAdrW-1:0] wrAdr;		// Address of write beat 0
		logic [31:0]         wrData;
		logic [3:0]          wrSel;
		logic [7:0]          wrBeats;
		logic [vramAdrW-1:0] clutBase;
		logic [7:0]          clutBeats;
		logic [63:0]         texL;		// Expected line with word 1 above word 0
		logic [63:0]         texR;
	} entryS;

	logic                gpuClk;
	logic                resetX;
	logic [cmdW-1:0]     cmdWord_i;
	logic                cmdReady_o;
	logic                busy_o;
	logic                clutReq_i;
	logic                clut8Bpp_i;
	logic [blkAdrW-1:0]  clutAdr_i;
	logic                texReqL_i;
	logic [texAdrW-1:0]  texAdrL_i;
	logic                texReqR_i;
	logic [texAdrW-1:0]  texAdrR_i;
	logic                texWrite_o;
	logic [texAdrW-1:0]  texWriteAdr_o;
	logic [63:0]         texData_o;
	logic                texDoneL_o;
	logic                texDoneR_o;
	logic                clutWrite_o;
	logic [6:0]          clutIndex_o;
	logic [busDataW-1:0] clutData_o;
	logic                clutDone_o;
	logic [vramAdrW-1:0] adr_o;
	logic [busDataW-1:0] dat_i;
	logic [busDataW-1:0] dat_o;
	logic [6:0]          cnt_o;
	logic [3:0]          sel_o;
	logic                wrt_o;
	logic                req_o;
	logic                ack_i;

	entryS tests[numTests];
	string testName[numTests];
	int    cycleCnt = 0;
	int    cycleLimit = 0;

	memArbiter DUT (.*);

	ddrModel ddr (
		.gpuClk (gpuClk),
		.req_i  (req_o),
		.wrt_i  (wrt_o),
		.cnt_i  (cnt_o),
		.adr_i  (adr_o),
		.dat_i  (dat_o),
		.sel_i  (sel_o),
		.ack_o  (ack_i),
		.dat_o  (dat_i)
	);

	always #50 gpuClk = ~gpuClk;	// 100 ns period

	// Run length guard
	always @(posedge gpuClk) begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt > cycleLimit) begin
			$display("Timeout: no result after %0d clock cycles", cycleLimit);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic checkVal(input string what, input logic [63:0] expV,
		input logic [63:0] actV);
		if (expV !== actV) begin
			$display("** Error %s: expected %h, actual %h", what, expV, actV);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Data the DDR side returns for a byte address
	function automatic logic [31:0] modelWord(input logic [vramAdrW-1:0] adr);
		logic [31:0] wordAdr;
		wordAdr = 32'(adr >> 2);
		return wordAdr * 32'h00010001;
	endfunction

	function automatic logic [cmdW-1:0] pairCmd(input logic [2:0] id,
		input logic [blkAdrW-1:0] blk, input logic [1:0] valid,
		input logic [15:0] colR, input logic [15:0] colL);
		return {colL, colR, valid, blk, id, 1'b0, cmdPixPair};
	endfunction

	function automatic logic [cmdW-1:0] fillCmd(input logic [blkAdrW-1:0] blk,
		input logic [15:0] col);
		return {col, 18'd0, blk, 3'd0, 1'b0, cmdFill};
	endfunction

	// ----------------------------------------------------------------------
	// Apply one table row and watch the outputs until idle again
	// ----------------------------------------------------------------------
	task automatic runEntry(input int idx);
		entryS       e;
		string       nm;
		int          expOrder[$];
		int          evCount;
		int          wrAcks;
		int          clutNo;
		int          texNo;
		int          nWr;
		logic [3:0]  hit;
		bit          finished;
		logic [55:0] logged;
		e        = tests[idx];
		nm       = testName[idx];
		evCount  = 0;
		wrAcks   = 0;
		clutNo   = 0;
		texNo    = 0;
		finished = 1'b0;
		// Completions must follow fixed priority among the raised clients
		for (int b = 0; b < 4; b++) begin
			if (e.reqMask[b])
				expOrder.push_back(b);
		end
		cmdWord_i  = e.reqMask[0] ? e.cmd : '0;
		clutReq_i  = e.reqMask[1];
		clut8Bpp_i = e.clut8;
		clutAdr_i  = e.clutAdr;
		texReqL_i  = e.reqMask[2];
		texAdrL_i  = e.texAdrL;
		texReqR_i  = e.reqMask[3];
		texAdrR_i  = e.texAdrR;
		while (!finished) begin
			@(negedge gpuClk);	// Outputs settled by mid cycle
			hit = 4'b0000;
			if (wrt_o && ack_i) begin
				wrAcks++;
				checkVal({nm, " write burst length"}, 64'(e.wrBeats - 8'd1), 64'(cnt_o));
				hit[0] = (wrAcks == int'(e.wrBeats));	// Last write beat
			end
			hit[1] = clutDone_o;
			hit[2] = texDoneL_o;
			hit[3] = texDoneR_o;
			if (clutWrite_o) begin
				checkVal({nm, " clut index"}, 64'(clutNo), 64'(clutIndex_o));
				checkVal({nm, " clut data"}, 64'(modelWord(e.clutBase + 20'(4 * clutNo))),
					64'(clutData_o));
				clutNo++;
			end
			if (clutDone_o)
				checkVal({nm, " clut burst length"}, 64'(e.clutBeats - 8'd1), 64'(cnt_o));
			if (texWrite_o || texDoneL_o || texDoneR_o) begin
				texNo++;
				checkVal({nm, " tex write with done"}, 64'(1), 64'(texWrite_o));
				checkVal({nm, " tex burst length"}, 64'(texBeats - 1), 64'(cnt_o));
				checkVal({nm, " tex line"}, 64'(texDoneR_o ? e.texAdrR : e.texAdrL),
					64'(texWriteAdr_o));
				checkVal({nm, " tex data"}, texDoneR_o ? e.texR : e.texL, texData_o);
			end
			for (int k = 0; k < 4; k++) begin
				if (hit[k]) begin
					if (evCount >= expOrder.size()) begin
						$display("%s: client %0d completed without a pending request",
							nm, k);
						$display("TEST FAIL");
						$fatal(1, "unexpected completion");
					end else begin
						checkVal({nm, " completion order"}, 64'(expOrder[evCount]),
							64'(k));
						evCount++;
					end
				end
			end
			finished = (evCount == expOrder.size()) && !busy_o;
			@(posedge gpuClk);
			#1;
			// Each client lets go once it has been served
			if (hit[0])
				cmdWord_i = '0;
			if (hit[1])
				clutReq_i = 1'b0;
			if (hit[2])
				texReqL_i = 1'b0;
			if (hit[3])
				texReqR_i = 1'b0;
		end
		checkVal({nm, " clut writes"}, 64'(e.clutBeats), 64'(clutNo));
		checkVal({nm, " tex lines"}, 64'(int'(e.reqMask[2]) + int'(e.reqMask[3])),
			64'(texNo));
		nWr = ddr.wrLog.size();
		checkVal({nm, " write beats"}, 64'(e.reqMask[0] ? e.wrBeats : 8'd0), 64'(nWr));
		for (int i = 0; i < nWr; i++) begin
			logged = ddr.wrLog.pop_front();
			checkVal({nm, " write adr"}, 64'(e.wrAdr + 20'(4 * i)), 64'(logged[55:36]));
			checkVal({nm, " write data"}, 64'(e.wrData), 64'(logged[35:4]));
			checkVal({nm, " write sel"}, 64'(e.wrSel), 64'(logged[3:0]));
		end
	endtask

	initial begin
		gpuClk     = 1'b0;
		resetX     = 1'b1;
		cmdWord_i  = '0;
		clutReq_i  = 1'b0;
		clut8Bpp_i = 1'b0;
		clutAdr_i  = '0;
		texReqL_i  = 1'b0;
		texAdrL_i  = '0;
		texReqR_i  = 1'b0;
		texAdrR_i  = '0;

		// mask, cmd, clutAdr, clut8, texL, texR, wrAdr, wrData, wrSel, wrBeats,
		// clutBase, clutBeats, texL data, texR data
		testName[0] = "fill";
		tests[0] = '{4'b0001, fillCmd(15'h0123, 16'hA5C3), 15'd0, 1'b0, 17'd0, 17'd0,
			20'h02460, 32'hA5C3A5C3, 4'hF, 8'd8, 20'd0, 8'd0, 64'd0, 64'd0};
		testName[1] = "pixel pair";
		tests[1] = '{4'b0001, pairCmd(3'd5, 15'h0040, 2'b10, 16'h1234, 16'hABCD), 15'd0,
			1'b0, 17'd0, 17'd0, 20'h00814, 32'h1234ABCD, 4'b1100, 8'd1, 20'd0, 8'd0,
			64'd0, 64'd0};
		testName[2] = "texture L";
		tests[2] = '{4'b0100, 56'd0, 15'd0, 1'b0, 17'h00010, 17'd0, 20'd0, 32'd0, 4'd0,
			8'd0, 20'd0, 8'd0, 64'h00210021_00200020, 64'd0};
		testName[3] = "texture R";
		tests[3] = '{4'b1000, 56'd0, 15'd0, 1'b0, 17'd0, 17'h00305, 20'd0, 32'd0, 4'd0,
			8'd0, 20'd0, 8'd0, 64'd0, 64'h060B060B_060A060A};
		testName[4] = "clut 4bpp";
		tests[4] = '{4'b0010, 56'd0, 15'h0010, 1'b0, 17'd0, 17'd0, 20'd0, 32'd0, 4'd0,
			8'd0, 20'h00200, 8'd8, 64'd0, 64'd0};
		testName[5] = "clut 8bpp";
		tests[5] = '{4'b0010, 56'd0, 15'h0400, 1'b1, 17'd0, 17'd0, 20'd0, 32'd0, 4'd0,
			8'd0, 20'h08000, 8'd128, 64'd0, 64'd0};
		// All four clients in one cycle
		testName[6] = "priority";
		tests[6] = '{4'b1111, pairCmd(3'd2, 15'h7FFF, 2'b01, 16'h0F0F, 16'hF0F0), 15'h0003,
			1'b0, 17'h00100, 17'h1FFF0, 20'hFFFE8, 32'h0F0FF0F0, 4'b0011, 8'd1, 20'h00060,
			8'd8, 64'h02010201_02000200, 64'hFFE4FFE1_FFE3FFE0};

		for (int i = 0; i < numTests; i++) begin
			cycleLimit += int'(tests[i].wrBeats) + int'(tests[i].clutBeats) + 10;
			cycleLimit += texBeats *
				(int'(tests[i].reqMask[2]) + int'(tests[i].reqMask[3]));
		end
		cycleLimit = cycleLimit * 2;

		repeat (3) @(posedge gpuClk);
		#1 resetX = 1'b0;
		@(negedge gpuClk);
		checkVal("reset outputs", 64'd0, 64'({req_o, wrt_o, texWrite_o, clutWrite_o,
			texDoneL_o, texDoneR_o, clutDone_o, busy_o}));
		checkVal("reset cmdReady", 64'(1), 64'(cmdReady_o));
		@(posedge gpuClk);
		#1;

		for (int i = 0; i < numTests; i++)
			runEntry(i);

		$display("TEST PASS");
		$finish;
	end

endmodule
